// File: rtl/dm_config.svh
`ifndef DM_CONFIG_SVH
`define DM_CONFIG_SVH

// Byte address bits, 4 KB space
`define DM_ADDR_WIDTH 12

`define DM_DATA_WIDTH 32

// Words in the data memory
`define DM_DEPTH 1024

`endif

// File: rtl/mem_op_pkg.sv
`include "dm_config.svh"

package mem_op_pkg;

   typedef enum logic [3:0] {
      OP_NONE = 4'd0,
      OP_SB   = 4'd1,
      OP_SH   = 4'd2,
      OP_SW   = 4'd3,
      OP_LB   = 4'd4,
      OP_LBU  = 4'd5,
      OP_LH   = 4'd6,
      OP_LHU  = 4'd7,
      OP_LW   = 4'd8
   } mem_op_e;

   // Same codes as EXT_MEM in the older core
   typedef enum logic [2:0] {
      KIND_BYTE   = 3'b000,
      KIND_BYTE_U = 3'b001,
      KIND_HALF   = 3'b010,
      KIND_HALF_U = 3'b011,
      KIND_WORD   = 3'b100
   } load_kind_e;

   function automatic logic is_store(mem_op_e op);
      return op inside {OP_SB, OP_SH, OP_SW};
   endfunction

   function automatic logic is_load(mem_op_e op);
      return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
   endfunction

   function automatic load_kind_e kind_of(mem_op_e op);
      case (op)
         OP_LB:   return KIND_BYTE;
         OP_LBU:  return KIND_BYTE_U;
         OP_LH:   return KIND_HALF;
         OP_LHU:  return KIND_HALF_U;
         default: return KIND_WORD;
      endcase
   endfunction

   // Halfwords need bit 0 clear, words need both low bits clear
   function automatic logic misaligned(mem_op_e op,
                                       logic [$clog2(`DM_DATA_WIDTH/8)-1:0] off);
      case (op)
         OP_SH, OP_LH, OP_LHU: return off[0];
         OP_SW, OP_LW:         return |off;
         default:              return 1'b0;
      endcase
   endfunction

endpackage

// File: rtl/mem_bus_pkg.sv
`include "dm_config.svh"

package mem_bus_pkg;

   localparam int BYTES_PER_WORD = `DM_DATA_WIDTH / 8;
   localparam int OFF_WIDTH      = $clog2(BYTES_PER_WORD);

   // One data word as stored in the array
   typedef logic [`DM_DATA_WIDTH-1:0] word_t;

   // One enable per byte lane
   typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

   // Word index, byte address without the offset bits
   typedef logic [`DM_ADDR_WIDTH-OFF_WIDTH-1:0] word_addr_t;

   typedef logic [OFF_WIDTH-1:0] byte_off_t;

endpackage

// File: rtl/mem_req_if.sv
`timescale 1ns/1ns

interface mem_req_if;
   import mem_op_pkg::*;
   import mem_bus_pkg::*;

   logic       valid;
   logic       write;     // Aligned store only
   byte_en_t   byte_en;
   word_addr_t word_addr;
   word_t      wdata;     // Already placed in its lanes
   load_kind_e kind;
   byte_off_t  byte_off;
   logic       fault;

   modport source (
      output valid, write, byte_en, word_addr, wdata, kind, byte_off, fault
   );

   modport sink (
      input valid, write, byte_en, word_addr, wdata, kind, byte_off, fault
   );

endinterface

// File: rtl/mem_rsp_if.sv
`timescale 1ns/1ns

interface mem_rsp_if;
   import mem_op_pkg::*;
   import mem_bus_pkg::*;

   logic       valid;     // Aligned load present
   word_t      rdata;     // Full addressed word
   load_kind_e kind;
   byte_off_t  byte_off;
   logic       fault;

   modport source (
      output valid, rdata, kind, byte_off, fault
   );

   modport sink (
      input valid, rdata, kind, byte_off, fault
   );

endinterface

// File: rtl/access_decode.sv
`timescale 1ns/1ns
`include "dm_config.svh"

module access_decode (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req_valid,
   input  mem_op_pkg::mem_op_e       req_op,
   input  logic [`DM_ADDR_WIDTH-1:0] req_addr,
   input  mem_bus_pkg::word_t        req_wdata,
   mem_req_if.source                 req
);
   import mem_op_pkg::*;
   import mem_bus_pkg::*;

   byte_off_t  off;
   word_addr_t waddr;
   logic       is_st;
   logic       is_ld;
   logic       bad_align;
   byte_en_t   be;
   word_t      lane_data;

   assign off       = req_addr[OFF_WIDTH-1:0];
   assign waddr     = req_addr[`DM_ADDR_WIDTH-1:OFF_WIDTH];
   assign is_st     = is_store(req_op);
   assign is_ld     = is_load(req_op);
   assign bad_align = misaligned(req_op, off);

   // Store data is replicated so every possible target lane holds it
   always_comb begin
      case (req_op)
         OP_SB: begin
            be        = byte_en_t'(1) << off;
            lane_data = {BYTES_PER_WORD{req_wdata[7:0]}};
         end
         OP_SH: begin
            be        = off[1] ? 4'b1100 : 4'b0011;    // Upper or lower half
            lane_data = {(BYTES_PER_WORD / 2){req_wdata[15:0]}};
         end
         OP_SW: begin
            be        = '1;
            lane_data = req_wdata;
         end
         default: begin
            be        = '0;
            lane_data = req_wdata;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         req.valid <= 1'b0;
         req.write <= 1'b0;
         req.fault <= 1'b0;
      end else begin
         req.valid <= req_valid && (is_st || is_ld);
         req.write <= req_valid && is_st && !bad_align;    // Misaligned store is dropped
         req.fault <= req_valid && bad_align;
      end
   end

   always_ff @(posedge clk) begin
      req.byte_en   <= be;
      req.word_addr <= waddr;
      req.wdata     <= lane_data;
      req.kind      <= kind_of(req_op);
      req.byte_off  <= off;
   end

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/1ns
`include "dm_config.svh"

module data_mem (
   input  logic      clk,
   input  logic      reset,
   mem_req_if.sink   req,
   mem_rsp_if.source rsp
);
   import mem_bus_pkg::*;

   word_t mem [`DM_DEPTH];
   logic  is_read;

   assign is_read = req.valid && !req.write && !req.fault;

   // Byte-enabled write, one lane at a time
   always_ff @(posedge clk) begin
      if (req.valid && req.write) begin
         for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (req.byte_en[i]) begin
               mem[req.word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rsp.valid <= 1'b0;
         rsp.fault <= 1'b0;
      end else begin
         rsp.valid <= is_read;
         rsp.fault <= req.valid && req.fault;
      end
   end

   // Registered read, control rides along with the word
   always_ff @(posedge clk) begin
      if (is_read) begin
         rsp.rdata <= mem[req.word_addr];
      end
      rsp.kind     <= req.kind;
      rsp.byte_off <= req.byte_off;
   end

endmodule

// File: rtl/load_extend.sv
`timescale 1ns/1ns

module load_extend (
   input  logic               clk,
   input  logic               reset,
   mem_rsp_if.sink            rsp,
   output logic               load_valid,
   output mem_bus_pkg::word_t load_data,
   output logic               align_fault
);
   import mem_op_pkg::*;
   import mem_bus_pkg::*;

   logic [7:0]  lane_byte;
   logic [15:0] lane_half;
   word_t       ext_data;

   assign lane_byte = rsp.rdata[8*rsp.byte_off +: 8];
   assign lane_half = rsp.byte_off[1] ? rsp.rdata[31:16] : rsp.rdata[15:0];

   always_comb begin
      case (rsp.kind)
         KIND_BYTE:   ext_data = {{24{lane_byte[7]}}, lane_byte};
         KIND_BYTE_U: ext_data = {24'h000000, lane_byte};
         KIND_HALF:   ext_data = {{16{lane_half[15]}}, lane_half};    // Same for both halves
         KIND_HALF_U: ext_data = {16'h0000, lane_half};
         default:     ext_data = rsp.rdata;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         load_valid  <= 1'b0;
         align_fault <= 1'b0;
         load_data   <= '0;
      end else begin
         load_valid  <= rsp.valid;
         align_fault <= rsp.fault;
         if (rsp.valid) begin
            load_data <= ext_data;    // Holds the last load otherwise
         end
      end
   end

endmodule

// File: rtl/mem_stage_top.sv
`timescale 1ns/1ns
`include "dm_config.svh"

module mem_stage_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req_valid,
   input  mem_op_pkg::mem_op_e       req_op,
   input  logic [`DM_ADDR_WIDTH-1:0] req_addr,
   input  mem_bus_pkg::word_t        req_wdata,
   output logic                      load_valid,
   output mem_bus_pkg::word_t        load_data,
   output logic                      align_fault
);

   mem_req_if req_bus ();
   mem_rsp_if rsp_bus ();

   // Decode, alignment check and lane placement
   access_decode access_decode_inst (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_op    (req_op),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req       (req_bus.source)
   );

   data_mem data_mem_inst (
      .clk   (clk),
      .reset (reset),
      .req   (req_bus.sink),
      .rsp   (rsp_bus.source)
   );

   // Lane select and sign or zero extension
   load_extend load_extend_inst (
      .clk         (clk),
      .reset       (reset),
      .rsp         (rsp_bus.sink),
      .load_valid  (load_valid),
      .load_data   (load_data),
      .align_fault (align_fault)
   );

endmodule

// File: testbench/mem_stage_properties.sv
`timescale 1ns/1ns
`include "dm_config.svh"

module mem_stage_properties (
   input logic                      clk,
   input logic                      reset,
   input logic                      req_valid,
   input mem_op_pkg::mem_op_e       req_op,
   input logic [`DM_ADDR_WIDTH-1:0] req_addr,
   input logic                      load_valid,
   input logic                      align_fault
);
   import mem_op_pkg::*;

   logic half_op;
   logic word_op;
   logic misaligned_req;

   assign half_op        = (req_op == OP_SH) || (req_op == OP_LH) || (req_op == OP_LHU);
   assign word_op        = (req_op == OP_SW) || (req_op == OP_LW);
   assign misaligned_req = req_valid && ((half_op && req_addr[0]) ||
                                         (word_op && (req_addr[1:0] != 2'b00)));

   never_both: assert property (@(posedge clk) disable iff (reset)
      !(load_valid && align_fault))
      else $error("load_valid and align_fault high in the same cycle");

   low_after_reset: assert property (@(posedge clk)
      reset |=> (!load_valid && !align_fault))
      else $error("Outputs not low in the cycle after reset");

   // Three register stages between request and fault
   fault_latency: assert property (@(posedge clk) disable iff (reset)
      misaligned_req |-> ##3 align_fault)
      else $error("align_fault missing three cycles after a misaligned request");

endmodule

bind mem_stage_top mem_stage_properties mem_stage_properties_inst (
   .clk         (clk),
   .reset       (reset),
   .req_valid   (req_valid),
   .req_op      (req_op),
   .req_addr    (req_addr),
   .load_valid  (load_valid),
   .align_fault (align_fault)
);

// File: testbench/mem_stage_tb.sv
`timescale 1ns/1ns
`include "dm_config.svh"

module mem_stage_tb;
   import mem_op_pkg::*;
   import mem_bus_pkg::*;

   localparam int RESET_CYCLES   = 10;
   localparam int LATENCY        = 3;
   localparam int RANDOM_OPS     = 2000;
   localparam int DIRECTED_SLOTS = 200;
   localparam int MAX_SLOTS      = DIRECTED_SLOTS + `DM_DEPTH + 2 * RANDOM_OPS;  // Idle slots too
   localparam longint TIMEOUT_NS = longint'(RESET_CYCLES + MAX_SLOTS + 50) * 10;

   typedef struct packed {
      int    issue;
      logic  load;
      logic  fault;
      word_t data;
   } expect_t;

   logic                      clk = 1'b0;
   logic                      reset;
   logic                      req_valid;
   mem_op_e                   req_op;
   logic [`DM_ADDR_WIDTH-1:0] req_addr;
   word_t                     req_wdata;
   logic                      load_valid;
   word_t                     load_data;
   logic                      align_fault;

   word_t   model_mem [`DM_DEPTH];
   expect_t pending [$];
   int      cycle  = 0;
   int      errors = 0;

   mem_stage_top mem_stage_top_inst (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (req_valid),
      .req_op      (req_op),
      .req_addr    (req_addr),
      .req_wdata   (req_wdata),
      .load_valid  (load_valid),
      .load_data   (load_data),
      .align_fault (align_fault)
   );

   always #5 clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   // Applies one request to the model memory and returns the expected outcome
   function automatic expect_t model_access(mem_op_e op, logic [11:0] addr, word_t wdata);
      expect_t     e;
      logic [9:0]  idx;
      logic [1:0]  off;
      word_t       w;
      logic [7:0]  b;
      logic [15:0] h;
      idx = addr[11:2];
      off = addr[1:0];
      w   = model_mem[idx];
      b   = 8'(w >> (8 * off));
      h   = 16'(w >> (8 * off));
      e   = '0;
      e.fault = ((op == OP_SH || op == OP_LH || op == OP_LHU) && off[0]) ||
                ((op == OP_SW || op == OP_LW) && off != 2'b00);
      e.load  = !e.fault && (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW});
      if (!e.fault) begin
         case (op)
            OP_SB:   model_mem[idx][8*off +: 8] = wdata[7:0];
            OP_SH:   model_mem[idx][8*off +: 16] = wdata[15:0];
            OP_SW:   model_mem[idx] = wdata;
            OP_LB:   e.data = {{24{b[7]}}, b};
            OP_LBU:  e.data = {24'h0, b};
            OP_LH:   e.data = {{16{h[15]}}, h};
            OP_LHU:  e.data = {16'h0, h};
            OP_LW:   e.data = w;
            default: ;
         endcase
      end
      return e;
   endfunction

   function automatic word_t fill_word(int unsigned idx);
      return {idx[9:0], 6'h2b, ~idx[9:0], 6'h15};
   endfunction

   task automatic issue(input mem_op_e op, input logic [11:0] addr, input word_t wdata);
      expect_t e;
      @(negedge clk);
      req_valid = 1'b1;
      req_op    = op;
      req_addr  = addr;
      req_wdata = wdata;
      e         = model_access(op, addr, wdata);
      e.issue   = cycle;
      pending.push_back(e);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         req_valid = 1'b0;
         req_op    = OP_NONE;
      end
   endtask

   // Compares each cycle's outputs with the oldest expectation
   always @(negedge clk) begin : compare
      expect_t e;
      logic    want_load;
      logic    want_fault;
      if (!reset) begin
         want_load  = 1'b0;
         want_fault = 1'b0;
         if (pending.size() > 0 && pending[0].issue + LATENCY == cycle) begin
            e          = pending.pop_front();
            want_load  = e.load;
            want_fault = e.fault;
            if (e.load && load_valid && load_data !== e.data) begin
               errors++;
               $display("mismatch at %0t: load_data expected %h actual %h",
                        $time, e.data, load_data);
            end
         end
         if (load_valid !== want_load) begin
            errors++;
            if (want_load)
               $display("mismatch at %0t: load_valid expected 1 actual %b", $time, load_valid);
            else
               $display("Unexpected load_valid pulse at %0t with no load issued", $time);
         end
         if (align_fault !== want_fault) begin
            errors++;
            if (want_fault)
               $display("mismatch at %0t: align_fault expected 1 actual %b", $time, align_fault);
            else
               $display("Unexpected align_fault pulse at %0t with no misaligned access", $time);
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns, the test did not complete", TIMEOUT_NS);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      mem_op_e     op;
      logic [11:0] addr;
      void'($urandom(44169));
      reset     = 1'b1;
      req_valid = 1'b0;
      req_op    = OP_NONE;
      req_addr  = '0;
      req_wdata = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;

      idle(20);    // Quiet outputs with no traffic
      if (load_data !== '0) begin
         errors++;
         $display("mismatch at %0t: load_data expected %h actual %h", $time, 32'h0, load_data);
      end

      for (int i = 0; i < `DM_DEPTH; i++) begin
         issue(OP_SW, 12'(i << 2), fill_word(i));
      end

      // Word store and load back to back and with a gap
      issue(OP_SW, 12'h040, 32'hdeadbeef);
      issue(OP_LW, 12'h040, 32'h0);
      issue(OP_SW, 12'h044, 32'h13579bdf);
      idle(2);
      issue(OP_LW, 12'h044, 32'h0);
      issue(OP_LW, 12'h040, 32'h0);

      // Byte lanes with bit 7 set and clear
      issue(OP_SW, 12'h080, 32'h0);
      for (int k = 0; k < 4; k++) begin
         issue(OP_SB, 12'h080 + 12'(k), {24'habcdef, (k[0] ? 8'h34 : 8'h81) ^ 8'(k << 4)});
         issue(OP_LW, 12'h080, 32'h0);
         issue(OP_LB, 12'h080 + 12'(k), 32'h0);
         issue(OP_LBU, 12'h080 + 12'(k), 32'h0);
      end

      // Halfwords at both aligned offsets
      issue(OP_SW, 12'h0c0, 32'hffffffff);
      issue(OP_SH, 12'h0c0, 32'h55558a5c);
      issue(OP_SH, 12'h0c2, 32'haaaa1234);
      for (int k = 0; k < 4; k += 2) begin
         issue(OP_LH, 12'h0c0 + 12'(k), 32'h0);
         issue(OP_LHU, 12'h0c0 + 12'(k), 32'h0);
      end
      issue(OP_LW, 12'h0c0, 32'h0);
      issue(OP_SH, 12'h0c0, 32'h00007fff);
      issue(OP_SH, 12'h0c2, 32'h0000c001);
      issue(OP_LH, 12'h0c0, 32'h0);
      issue(OP_LH, 12'h0c2, 32'h0);
      issue(OP_LW, 12'h0c0, 32'h0);

      // Misaligned accesses fault and leave memory alone
      issue(OP_SW, 12'h100, 32'h5555aaaa);
      issue(OP_SH, 12'h101, 32'h0000ffff);
      issue(OP_SW, 12'h102, 32'h12345678);
      issue(OP_SW, 12'h103, 32'h87654321);
      issue(OP_LH, 12'h103, 32'h0);
      issue(OP_LHU, 12'h101, 32'h0);
      issue(OP_LW, 12'h102, 32'h0);
      idle(1);
      issue(OP_LW, 12'h100, 32'h0);

      for (int i = 0; i < RANDOM_OPS; i++) begin
         op = mem_op_e'($urandom_range(0, 8));
         if ($urandom_range(0, 1) == 0)
            addr = 12'($urandom);
         else
            addr = 12'($urandom_range(0, 63));    // Narrow window for store-load reuse
         issue(op, addr, $urandom);
         if ($urandom_range(0, 7) == 0) idle(1);
      end

      while (pending.size() != 0) idle(1);
      idle(2);

      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: flist.f
+incdir+rtl
rtl/mem_op_pkg.sv
rtl/mem_bus_pkg.sv
rtl/mem_req_if.sv
rtl/mem_rsp_if.sv
rtl/access_decode.sv
rtl/data_mem.sv
rtl/load_extend.sv
rtl/mem_stage_top.sv
testbench/mem_stage_properties.sv
testbench/mem_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module mem_stage_tb \
   -f flist.f \
   -o mem_stage_sim

./obj_dir/mem_stage_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi

echo "Simulation finished without a reported failure"
